//--- hdl/dcache_pkg.sv
package dcache_pkg;

	// geometry
	localparam int addr_w = 32;
	localparam int word_w = 64;
	localparam int byte_w = 8;
	localparam int words_per_line = 4;
	localparam int num_sets = 16;
	localparam int num_ways = 2;

	// address split: tag | index | word select | byte in word
	localparam int offset_w = 5;
	localparam int word_sel_w = 2;
	localparam int index_w = 4;
	localparam int tag_w = addr_w - index_w - offset_w; // 23
	localparam int line_w = word_w * words_per_line;
	localparam int be_w = word_w / byte_w;

	typedef logic [addr_w-1:0] addr_t;
	typedef logic [word_w-1:0] word_t;
	typedef logic [line_w-1:0] line_t;
	typedef logic [tag_w-1:0] tag_t;
	typedef logic [index_w-1:0] index_t;
	typedef logic [word_sel_w-1:0] word_sel_t;
	typedef logic [be_w-1:0] byte_en_t;
	typedef logic way_t;

	// miss handling walks writeback -> fill -> lookup again
	typedef enum logic [2:0] {
		idle,
		lookup,
		writeback,
		fill,
		finish,
		respond
	} ctrl_state_t;

endpackage

//--- hdl/array_if.sv
`timescale 1ns/1ps

interface array_if import dcache_pkg::*; ();
	// lookup address, registered in the controller
	tag_t tag;
	index_t index;
	word_sel_t word_sel;

	// hit-way access; write_be of zero is a plain read touch
	word_t write_word;
	byte_en_t write_be;
	logic write_hit;

	// victim way updates
	logic fill;
	line_t fill_line;
	logic clean;

	// combinational lookup results
	logic hit;
	way_t hit_way;
	word_t read_word;
	way_t victim_way;
	logic victim_dirty;
	tag_t victim_tag;
	line_t victim_line;

	modport ctrl (
		output tag, index, word_sel, write_word, write_be, write_hit,
		output fill, fill_line, clean,
		input hit, hit_way, read_word, victim_way, victim_dirty, victim_tag, victim_line
	);

	modport mem (
		input tag, index, word_sel, write_word, write_be, write_hit,
		input fill, fill_line, clean,
		output hit, hit_way, read_word, victim_way, victim_dirty, victim_tag, victim_line
	);
endinterface

//--- hdl/mem_if.sv
`timescale 1ns/1ps

interface mem_if import dcache_pkg::*; ();
	logic start; // one cycle pulse
	logic write;
	addr_t line_addr; // line aligned
	line_t wline;

	logic done; // handshake fully closed
	line_t rline;

	modport ctrl (
		output start,
		output write,
		output line_addr,
		output wline,
		input done,
		input rline
	);

	modport port (
		input start,
		input write,
		input line_addr,
		input wline,
		output done,
		output rline
	);
endinterface

//--- hdl/cache_arrays.sv
`timescale 1ns/1ps

module cache_arrays import dcache_pkg::*; (
	input logic clk,
	input logic reset,
	array_if.mem arr
);

	tag_t tags [num_ways][num_sets];
	word_t data_q [num_ways][num_sets][words_per_line];
	logic [num_sets-1:0] valid [num_ways];
	logic [num_sets-1:0] dirty [num_ways];
	logic [num_sets-1:0] lru; // least recently used way per set

	index_t idx;
	word_sel_t ws;
	logic [num_ways-1:0] way_hit;
	way_t hw;
	way_t vic;
	line_t vic_line;

	assign idx = arr.index;
	assign ws = arr.word_sel;

	always_comb begin
		for (int w = 0; w < num_ways; w++) begin
			way_hit[w] = valid[w][idx] && (tags[w][idx] == arr.tag);
		end
	end

	assign hw = way_hit[1];
	assign arr.hit = |way_hit;
	assign arr.hit_way = hw;
	assign arr.read_word = data_q[hw][idx][ws];

	// invalid way first, otherwise lru
	always_comb begin
		if (!valid[0][idx])
			vic = 1'b0;
		else if (!valid[1][idx])
			vic = 1'b1;
		else
			vic = lru[idx];
	end

	always_comb begin
		for (int i = 0; i < words_per_line; i++) begin
			vic_line[i*word_w +: word_w] = data_q[vic][idx][i]; // word 0 lowest
		end
	end

	assign arr.victim_way = vic;
	assign arr.victim_dirty = valid[vic][idx] && dirty[vic][idx];
	assign arr.victim_tag = tags[vic][idx];
	assign arr.victim_line = vic_line;

	// state bits
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int w = 0; w < num_ways; w++) begin
				valid[w] <= '0;
				dirty[w] <= '0;
			end
			lru <= '0;
		end else if (arr.fill) begin
			valid[vic][idx] <= 1'b1;
			dirty[vic][idx] <= 1'b0;
			lru[idx] <= ~vic;
		end else if (arr.write_hit) begin
			if (|arr.write_be)
				dirty[hw][idx] <= 1'b1;
			lru[idx] <= ~hw; // reads touch too
		end else if (arr.clean) begin
			dirty[vic][idx] <= 1'b0;
		end
	end

	// tags and line data
	always_ff @(posedge clk) begin
		if (arr.fill) begin
			tags[vic][idx] <= arr.tag;
			for (int i = 0; i < words_per_line; i++) begin
				data_q[vic][idx][i] <= arr.fill_line[i*word_w +: word_w];
			end
		end else if (arr.write_hit) begin
			for (int b = 0; b < be_w; b++) begin
				if (arr.write_be[b])
					data_q[hw][idx][ws][b*byte_w +: byte_w] <= arr.write_word[b*byte_w +: byte_w];
			end
		end
	end

	a_fill_vs_write: assert property (@(posedge clk) disable iff (reset)
		!(arr.fill && arr.write_hit))
		else $error("fill and hit write in the same cycle");

	// a refill of a line already present would leave two copies
	a_one_hit: assert property (@(posedge clk) disable iff (reset)
		!(way_hit[0] && way_hit[1]))
		else $error("both ways hit for tag %h set %0d", arr.tag, idx);

endmodule

//--- hdl/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl import dcache_pkg::*; (
	input logic clk,
	input logic reset,
	input logic cpu_req,
	input logic cpu_we,
	input addr_t cpu_addr,
	input word_t cpu_wdata,
	input byte_en_t cpu_be,
	output logic cpu_ack,
	output word_t cpu_rdata,
	array_if.ctrl arr,
	mem_if.ctrl mem
);

	ctrl_state_t state;

	// request held for the whole transaction
	addr_t req_addr;
	logic req_we;
	word_t req_wdata;
	byte_en_t req_be;
	word_t rdata_q;

	tag_t req_tag;
	index_t req_index;
	logic dirty_miss;

	assign req_tag = req_addr[addr_w-1 -: tag_w];
	assign req_index = req_addr[offset_w +: index_w];

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idle;
		end else begin
			case (state)
				idle: begin
					if (cpu_req)
						state <= lookup;
				end
				lookup: begin
					if (arr.hit)
						state <= finish;
					else if (arr.victim_dirty)
						state <= writeback;
					else
						state <= fill;
				end
				writeback: begin
					if (mem.done)
						state <= fill; // read goes out on the same edge
				end
				fill: begin
					if (mem.done)
						state <= lookup; // hits now
				end
				finish: begin
					state <= respond;
				end
				respond: begin
					if (!cpu_req)
						state <= idle;
				end
				default: begin
					state <= idle;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == idle && cpu_req) begin
			req_addr <= cpu_addr;
			req_we <= cpu_we;
			req_wdata <= cpu_wdata;
			req_be <= cpu_be;
		end
		if (state == finish)
			rdata_q <= arr.read_word;
	end

	assign cpu_ack = (state == respond);
	assign cpu_rdata = rdata_q;

	// array side
	assign arr.tag = req_tag;
	assign arr.index = req_index;
	assign arr.word_sel = req_addr[offset_w-1 -: word_sel_w];
	assign arr.write_hit = (state == finish); // merge lands on entry to respond
	assign arr.write_word = req_wdata;
	assign arr.write_be = req_we ? req_be : '0;
	assign arr.fill = (state == fill) && mem.done;
	assign arr.fill_line = mem.rline;
	assign arr.clean = (state == writeback) && mem.done;

	// memory side
	assign dirty_miss = (state == lookup) && !arr.hit && arr.victim_dirty;

	assign mem.start = ((state == lookup) && !arr.hit) || ((state == writeback) && mem.done);
	assign mem.write = dirty_miss;
	assign mem.wline = arr.victim_line;

	always_comb begin
		if (dirty_miss)
			mem.line_addr = {arr.victim_tag, req_index, {offset_w{1'b0}}};
		else
			mem.line_addr = {req_tag, req_index, {offset_w{1'b0}}};
	end

	a_ack_needs_req: assert property (@(posedge clk) disable iff (reset)
		$rose(cpu_ack) |-> $past(cpu_req))
		else $error("cpu_ack raised without a request");

	// the refilled line must hit in the way that was picked as victim
	a_fill_way: assert property (@(posedge clk) disable iff (reset)
		$past(arr.fill) |-> arr.hit && (arr.hit_way == $past(arr.victim_way)))
		else $error("refilled line not found in the victim way");

endmodule

//--- hdl/mem_port.sv
`timescale 1ns/1ps

module mem_port import dcache_pkg::*; (
	input logic clk,
	input logic reset,
	mem_if.port mem,
	output logic mem_req,
	output logic mem_we,
	output addr_t mem_addr,
	output line_t mem_wdata,
	input logic mem_ack,
	input line_t mem_rdata
);

	logic open; // transfer started, ack not yet seen low
	line_t rline_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			mem_req <= 1'b0;
			mem_we <= 1'b0;
			open <= 1'b0;
			mem.done <= 1'b0;
		end else begin
			mem.done <= 1'b0;
			if (mem.start) begin
				mem_req <= 1'b1;
				mem_we <= mem.write;
				open <= 1'b1;
			end else if (mem_req && mem_ack) begin
				mem_req <= 1'b0;
			end else if (open && !mem_req && !mem_ack) begin
				open <= 1'b0;
				mem.done <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (mem.start) begin
			mem_addr <= mem.line_addr;
			mem_wdata <= mem.wline;
		end
		if (mem_req && mem_ack && !mem_we)
			rline_q <= mem_rdata; // only valid while ack is high
	end

	assign mem.rline = rline_q;

	a_start_idle: assert property (@(posedge clk) disable iff (reset)
		mem.start |-> !open)
		else $error("start while a memory transfer is open");

endmodule

//--- hdl/dcache_top.sv
`timescale 1ns/1ps

module dcache_top import dcache_pkg::*; (
	input logic clk,
	input logic reset,

	// cpu, four-phase
	input logic cpu_req,
	input logic cpu_we,
	input addr_t cpu_addr,
	input word_t cpu_wdata,
	input byte_en_t cpu_be,
	output logic cpu_ack,
	output word_t cpu_rdata,

	// memory, four-phase, one line per transfer
	output logic mem_req,
	output logic mem_we,
	output addr_t mem_addr,
	output line_t mem_wdata,
	input logic mem_ack,
	input line_t mem_rdata
);

	array_if arr_i ();
	mem_if mem_i ();

	cache_arrays cache_arrays_i (
		.clk(clk),
		.reset(reset),
		.arr(arr_i)
	);

	cache_ctrl cache_ctrl_i (
		.clk(clk),
		.reset(reset),
		.cpu_req(cpu_req),
		.cpu_we(cpu_we),
		.cpu_addr(cpu_addr),
		.cpu_wdata(cpu_wdata),
		.cpu_be(cpu_be),
		.cpu_ack(cpu_ack),
		.cpu_rdata(cpu_rdata),
		.arr(arr_i),
		.mem(mem_i)
	);

	mem_port mem_port_i (
		.clk(clk),
		.reset(reset),
		.mem(mem_i),
		.mem_req(mem_req),
		.mem_we(mem_we),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_ack(mem_ack),
		.mem_rdata(mem_rdata)
	);

endmodule

//--- bench/tb_checks.svh
task automatic word_cmp(input string name, input word_t got, input word_t exp);
	if (got !== exp) begin
		$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
		fail_run("word value differs from the shadow memory");
	end
endtask

task automatic addr_cmp(input string name, input addr_t got, input addr_t exp);
	if (got !== exp) begin
		$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
		fail_run("memory transfer went to the wrong line");
	end
endtask

task automatic line_cmp(input string name, input line_t got, input line_t exp);
	if (got !== exp) begin
		$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
		fail_run("written back line differs from the model");
	end
endtask

// a hit uses no memory and acks on the third falling edge after the request
task automatic hit_cmp(input logic exp_hit, input int transfers, input int cycles);
	if (exp_hit !== (transfers == 0)) begin
		$display("Mismatch at %0t: hit got %0b expected %0b", $time, transfers == 0, exp_hit);
		fail_run("hit or miss differs from the model");
	end
	if (exp_hit && cycles != 3) begin
		$display("Mismatch at %0t: cpu_ack latency got %0d expected 3", $time, cycles);
		fail_run("hit latency is wrong");
	end
endtask

task automatic await_ack(output int cycles);
	cycles = 0;
	while (!cpu_ack) begin
		@(negedge clk);
		cycles++;
		if (cycles > 200)
			fail_run("timeout waiting for cpu_ack to rise");
	end
endtask

task automatic await_release();
	int n;
	n = 0;
	while (cpu_ack) begin
		@(negedge clk);
		n++;
		if (n > 20)
			fail_run("timeout waiting for cpu_ack to fall after cpu_req dropped");
	end
endtask

//--- bench/tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache import dcache_pkg::*; ();

	logic clk = 1'b0;
	logic reset;
	logic cpu_req, cpu_we, cpu_ack;
	addr_t cpu_addr;
	word_t cpu_wdata, cpu_rdata;
	byte_en_t cpu_be;
	logic mem_req, mem_we, mem_ack;
	addr_t mem_addr;
	line_t mem_wdata, mem_rdata;

	integer seed = 32'hc9de_b836;

	line_t mem_lines [addr_t]; // memory model, sparse
	word_t shadow [addr_t]; // expected contents by word address
	logic op_we [$];
	addr_t op_addr [$];
	line_t op_line [$];
	int ack_wait = 0;

	// cache model
	tag_t m_tag [num_ways][num_sets];
	logic m_valid [num_ways][num_sets];
	logic m_dirty [num_ways][num_sets];
	way_t m_lru [num_sets];

	dcache_top dcache_top_i (.*);

	always #5 clk = ~clk;

	task automatic fail_run(input string why);
		$display(">>> FAIL");
		$fatal(1, "%s", why);
	endtask

	`include "tb_checks.svh"

	function automatic word_t pattern_word(addr_t a);
		return {a, ~a ^ 32'h5a5a_3c3c};
	endfunction

	function automatic word_t shadow_word(addr_t a);
		return shadow.exists(a) ? shadow[a] : pattern_word(a);
	endfunction

	function automatic line_t shadow_line(addr_t a);
		line_t l;
		for (int i = 0; i < words_per_line; i++)
			l[i*word_w +: word_w] = shadow_word(a + i * 8);
		return l;
	endfunction

	function automatic line_t memory_line(addr_t a);
		line_t l;
		for (int i = 0; i < words_per_line; i++)
			l[i*word_w +: word_w] = pattern_word(a + i * 8);
		return mem_lines.exists(a) ? mem_lines[a] : l;
	endfunction

	// memory answers on the falling edge after a random delay
	always @(negedge clk) begin
		if (reset) begin
			mem_ack = 1'b0;
		end else if (mem_req && !mem_ack) begin
			if (ack_wait > 0) begin
				ack_wait--;
			end else begin
				if (mem_we)
					mem_lines[mem_addr] = mem_wdata;
				else
					mem_rdata = memory_line(mem_addr);
				op_we.push_back(mem_we);
				op_addr.push_back(mem_addr);
				op_line.push_back(mem_wdata);
				mem_ack = 1'b1;
			end
		end else if (!mem_req && mem_ack) begin
			mem_ack = 1'b0;
			ack_wait = {$random(seed)} % 4;
		end
	end

	initial begin
		logic we, exp_hit, vic_dirty;
		byte_en_t be;
		word_t wdata, exp_rdata, w;
		index_t idx;
		tag_t tag;
		addr_t addr, vic_addr;
		way_t vic, way;
		line_t vic_line;
		int cycles, k, n_hits, n_wb;

		reset = 1'b1;
		{cpu_req, cpu_we, cpu_addr, cpu_wdata, cpu_be} = '0;
		mem_ack = 1'b0;
		mem_rdata = '0;
		n_hits = 0;
		n_wb = 0;
		for (int s = 0; s < num_sets; s++) begin
			m_lru[s] = 1'b0;
			for (int v = 0; v < num_ways; v++) begin
				m_tag[v][s] = '0;
				m_valid[v][s] = 1'b0;
				m_dirty[v][s] = 1'b0;
			end
		end
		repeat (5) @(negedge clk);
		reset = 1'b0;
		if (cpu_ack !== 1'b0 || mem_req !== 1'b0)
			fail_run("cpu_ack or mem_req not low after reset");

		for (int n = 0; n < 300; n++) begin
			we = $random(seed);
			be = $random(seed);
			wdata = {$random(seed), $random(seed)};
			idx = 4 + ({$random(seed)} % 3); // few sets, four tags each
			tag = 23'h2b51c + ({$random(seed)} % 4);
			addr = {tag, idx, 2'($random(seed)), 3'b000};

			exp_hit = 1'b0;
			way = 1'b0;
			for (int v = 0; v < num_ways; v++) begin
				if (m_valid[v][idx] && m_tag[v][idx] == tag) begin
					exp_hit = 1'b1;
					way = way_t'(v);
				end
			end
			if (!m_valid[0][idx])
				vic = 1'b0;
			else if (!m_valid[1][idx])
				vic = 1'b1;
			else
				vic = m_lru[idx];
			vic_dirty = !exp_hit && m_valid[vic][idx] && m_dirty[vic][idx];
			vic_addr = {m_tag[vic][idx], idx, 5'b0};
			vic_line = shadow_line(vic_addr);
			exp_rdata = shadow_word(addr);

			op_we.delete();
			op_addr.delete();
			op_line.delete();
			cpu_req = 1'b1;
			cpu_we = we;
			cpu_addr = addr;
			cpu_wdata = wdata;
			cpu_be = be;
			await_ack(cycles);
			hit_cmp(exp_hit, op_addr.size(), cycles);
			if (!we)
				word_cmp("cpu_rdata", cpu_rdata, exp_rdata);

			if (!exp_hit) begin
				if (op_addr.size() != (vic_dirty ? 2 : 1))
					fail_run("wrong number of memory transfers on a miss");
				k = 0;
				if (vic_dirty) begin
					if (!op_we[0])
						fail_run("dirty victim was not written back before the fill");
					addr_cmp("mem_addr", op_addr[0], vic_addr);
					line_cmp("mem_wdata", op_line[0], vic_line);
					k = 1;
					n_wb++;
				end
				if (op_we[k])
					fail_run("line fill was issued as a memory write");
				addr_cmp("mem_addr", op_addr[k], {tag, idx, 5'b0});
				m_tag[vic][idx] = tag;
				m_valid[vic][idx] = 1'b1;
				m_dirty[vic][idx] = 1'b0;
				way = vic;
			end else begin
				n_hits++;
			end
			m_lru[idx] = ~way;
			if (we && |be) begin
				m_dirty[way][idx] = 1'b1;
				w = shadow_word(addr);
				for (int b = 0; b < be_w; b++)
					if (be[b])
						w[b*byte_w +: byte_w] = wdata[b*byte_w +: byte_w];
				shadow[addr] = w;
			end

			cpu_req = 1'b0;
			await_release();
			repeat ({$random(seed)} % 3) @(negedge clk);
		end

		$display("%0d hits, %0d write-backs", n_hits, n_wb);
		if (n_hits > 0 && n_wb > 0) begin
			$display(">>> PASS");
			$finish;
		end else begin
			fail_run("stimulus never produced both a hit and a write-back");
		end
	end

endmodule

//--- list.f
+incdir+bench
hdl/dcache_pkg.sv
hdl/array_if.sv
hdl/mem_if.sv
hdl/cache_arrays.sv
hdl/cache_ctrl.sv
hdl/mem_port.sv
hdl/dcache_top.sv
bench/tb_dcache.sv
